// ==== hw/bus_controller.sv ====
`include "soc_macros.svh"

module bus_controller import bus_pkg::*; (
  input  logic  clock,
  input  logic  rst_n,
  input  addr_t cpu_address,
  input  logic  cpu_read,
  input  logic  cpu_write,
  input  data_t cpu_writedata,
  input  be_t   cpu_be,
  input  addr_t vga_address,
  input  logic  vga_read,
  input  data_t rom_readdata,
  input  data_t ram_readdata,
  input  data_t io_readdata,
  output data_t readdata,
  output logic  cpu_wait,
  output logic  vga_wait,
  bus_if.ctrl   bus
);

  bus_state_t state_q;
  logic       grant_vga_q;
  logic       rd_q;
  logic       wr_q;
  cs_t        cs_q;
  addr_t      addr_q;
  data_t      wdata_q;
  be_t        be_q;
  logic       cpu_req;
  logic       vga_req;
  logic       grant;
  addr_t      grant_addr;
  cs_t        cs_dec;

  assign cpu_req    = cpu_read | cpu_write;
  assign vga_req    = vga_read;
  assign grant      = (state_q == idle) && (vga_req || cpu_req);
  // Display fetch wins ties
  assign grant_addr = vga_req ? vga_address : cpu_address;

  always_comb begin
    case (grant_addr[31:28])
      `SOC_REGION_ROM: cs_dec = 3'b001;
      `SOC_REGION_RAM: cs_dec = 3'b010;
      `SOC_REGION_IO:  cs_dec = 3'b100;
      default:         cs_dec = 3'b000;
    endcase
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= idle;
      grant_vga_q <= 1'b0;
      rd_q        <= 1'b0;
      wr_q        <= 1'b0;
      cs_q        <= '0;
    end else begin
      case (state_q)
        idle: begin
          if (grant) begin
            state_q     <= access;
            grant_vga_q <= vga_req;
            rd_q        <= vga_req || (cpu_read && !cpu_write);
            wr_q        <= !vga_req && cpu_write;
            cs_q        <= cs_dec;
          end
        end
        access:  state_q <= respond;
        respond: begin
          state_q <= idle;
          rd_q    <= 1'b0;
          wr_q    <= 1'b0;
          cs_q    <= '0;
        end
        default: state_q <= idle;
      endcase
    end
  end

  // Winner's payload, held for the whole transfer
  always_ff @(posedge clock) begin
    if (grant) begin
      addr_q  <= grant_addr;
      wdata_q <= cpu_writedata;
      be_q    <= vga_req ? 4'hf : cpu_be;
    end
  end

  assign bus.address   = addr_q;
  assign bus.writedata = wdata_q;
  assign bus.be        = be_q;
  assign bus.read      = (state_q == access) && rd_q;
  assign bus.write     = (state_q == access) && wr_q;
  assign bus.cs        = cs_q;

  // Wait drops only for the master being answered
  assign cpu_wait = cpu_req && !((state_q == respond) && !grant_vga_q);
  assign vga_wait = vga_req && !((state_q == respond) && grant_vga_q);

  assign readdata = (cs_q[`SOC_REGION_ROM] ? rom_readdata : 32'h0) |
                    (cs_q[`SOC_REGION_RAM] ? ram_readdata : 32'h0) |
                    (cs_q[`SOC_REGION_IO]  ? io_readdata  : 32'h0);

  a_cs_onehot: assert property (@(posedge clock) disable iff (!rst_n) $onehot0(bus.cs));

  a_no_rd_wr: assert property (@(posedge clock) disable iff (!rst_n)
    !(bus.read && bus.write));

  // Completion answers the request that was latched at the grant
  a_cpu_done: assert property (@(posedge clock) disable iff (!rst_n)
    cpu_req && !cpu_wait |-> $past(cpu_req) && $past(cpu_req, 2) && addr_q == cpu_address);

  a_vga_done: assert property (@(posedge clock) disable iff (!rst_n)
    vga_req && !vga_wait |-> $past(vga_req) && $past(vga_req, 2) && addr_q == vga_address);

endmodule

// ==== hw/bus_if.sv ====
interface bus_if import bus_pkg::*; ();

  addr_t address;
  data_t writedata;
  be_t   be;
  logic  read;
  logic  write;
  cs_t   cs;

  modport ctrl (
    output address,
    output writedata,
    output be,
    output read,
    output write,
    output cs
  );

  modport slave (
    input address,
    input writedata,
    input be,
    input read,
    input write,
    input cs
  );

endinterface

// ==== hw/bus_pkg.sv ====
package bus_pkg;

  // Byte address, top nibble picks the region
  typedef logic [31:0] addr_t;

  typedef logic [31:0] data_t;

  // Bit n enables byte lane n
  typedef logic [3:0] be_t;

  // One-hot: rom, ram, io
  typedef logic [2:0] cs_t;

  typedef enum logic [1:0] {
    idle,
    access,
    respond
  } bus_state_t;

endpackage

// ==== hw/io_pkg.sv ====
package io_pkg;

  typedef logic [17:0] led_t;

  typedef logic [3:0] nibble_t;

  // Active low, bit 0 is segment a
  typedef logic [6:0] seg7_t;

endpackage

// ==== hw/io_regs.sv ====
`include "soc_macros.svh"

module io_regs import bus_pkg::*, io_pkg::*; (
  input  logic         clock,
  input  logic         rst_n,
  bus_if.slave         bus,
  output data_t        readdata,
  output led_t         leds,
  output seg7_t [7:0]  hex_segs
);

  led_t  led_q;
  data_t hex_q;
  logic  sel;

  assign sel = bus.cs[`SOC_REGION_IO];

  function automatic seg7_t hex_to_seg(nibble_t d);
    case (d)
      4'h0:    hex_to_seg = 7'b1000000;
      4'h1:    hex_to_seg = 7'b1111001;
      4'h2:    hex_to_seg = 7'b0100100;
      4'h3:    hex_to_seg = 7'b0110000;
      4'h4:    hex_to_seg = 7'b0011001;
      4'h5:    hex_to_seg = 7'b0010010;
      4'h6:    hex_to_seg = 7'b0000010;
      4'h7:    hex_to_seg = 7'b1111000;
      4'h8:    hex_to_seg = 7'b0000000;
      4'h9:    hex_to_seg = 7'b0010000;
      4'ha:    hex_to_seg = 7'b0001000;
      4'hb:    hex_to_seg = 7'b0000011;
      4'hc:    hex_to_seg = 7'b1000110;
      4'hd:    hex_to_seg = 7'b0100001;
      4'he:    hex_to_seg = 7'b0000110;
      default: hex_to_seg = 7'b0001110;
    endcase
  endfunction

  // Word 0 is leds, word 1 is the hex display
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      led_q <= '0;
      hex_q <= '0;
    end else if (sel && bus.write) begin
      if (!bus.address[2]) begin
        if (bus.be[0]) led_q[7:0]   <= bus.writedata[7:0];
        if (bus.be[1]) led_q[15:8]  <= bus.writedata[15:8];
        if (bus.be[2]) led_q[17:16] <= bus.writedata[17:16];
      end else begin
        for (int i = 0; i < 4; i++) begin
          if (bus.be[i]) hex_q[8*i +: 8] <= bus.writedata[8*i +: 8];
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (sel && bus.read) begin
      readdata <= bus.address[2] ? hex_q : {14'h0, led_q};
    end
  end

  assign leds = led_q;

  always_comb begin
    for (int i = 0; i < 8; i++) begin
      hex_segs[i] = hex_to_seg(hex_q[4*i +: 4]);
    end
  end

endmodule

// ==== hw/scratch_ram.sv ====
`include "soc_macros.svh"

module scratch_ram import bus_pkg::*; (
  input  logic  clock,
  bus_if.slave  bus,
  output data_t readdata
);

  localparam int IDX_W = $clog2(`SOC_RAM_WORDS);

  data_t             mem [`SOC_RAM_WORDS];
  logic [IDX_W-1:0]  idx;
  logic              sel;

  // Word index, byte offset dropped
  assign idx = bus.address[IDX_W+1:2];
  assign sel = bus.cs[`SOC_REGION_RAM];

  always_ff @(posedge clock) begin
    if (sel && bus.write) begin
      for (int i = 0; i < 4; i++) begin
        if (bus.be[i]) begin
          mem[idx][8*i +: 8] <= bus.writedata[8*i +: 8];
        end
      end
    end
  end

  // Held until the next read strobe
  always_ff @(posedge clock) begin
    if (sel && bus.read) begin
      readdata <= mem[idx];
    end
  end

endmodule

// ==== hw/soc.sv ====
module soc import bus_pkg::*, io_pkg::*; (
  input  logic         clock,
  input  logic         rst_n,
  // CPU master
  input  addr_t        cpu_address,
  input  logic         cpu_read,
  input  logic         cpu_write,
  input  data_t        cpu_writedata,
  input  be_t          cpu_be,
  output data_t        cpu_readdata,
  output logic         cpu_wait,
  // Display fetch master, reads only
  input  addr_t        vga_address,
  input  logic         vga_read,
  output data_t        vga_readdata,
  output logic         vga_wait,
  output led_t         leds,
  output seg7_t [7:0]  hex_segs
);

  data_t bm_readdata;
  data_t rom_readdata;
  data_t ram_readdata;
  data_t io_readdata;

  bus_if bus ();

  // Both masters see the same mux output
  assign cpu_readdata = bm_readdata;
  assign vga_readdata = bm_readdata;

  bus_controller bc0 (
    .clock(clock), .rst_n(rst_n),
    .cpu_address(cpu_address), .cpu_read(cpu_read), .cpu_write(cpu_write),
    .cpu_writedata(cpu_writedata), .cpu_be(cpu_be),
    .vga_address(vga_address), .vga_read(vga_read),
    .rom_readdata(rom_readdata), .ram_readdata(ram_readdata), .io_readdata(io_readdata),
    .readdata(bm_readdata), .cpu_wait(cpu_wait), .vga_wait(vga_wait),
    .bus(bus.ctrl)
  );

  vector_rom rom0 (.clock(clock), .bus(bus.slave), .readdata(rom_readdata));

  scratch_ram ram0 (.clock(clock), .bus(bus.slave), .readdata(ram_readdata));

  io_regs io0 (
    .clock(clock), .rst_n(rst_n), .bus(bus.slave),
    .readdata(io_readdata), .leds(leds), .hex_segs(hex_segs)
  );

endmodule

// ==== hw/vector_rom.sv ====
`include "soc_macros.svh"

module vector_rom import bus_pkg::*; (
  input  logic  clock,
  bus_if.slave  bus,
  output data_t readdata
);

  localparam int IDX_W = $clog2(`SOC_ROM_WORDS);

  data_t rom [`SOC_ROM_WORDS];

  initial begin
    for (int i = 0; i < `SOC_ROM_WORDS; i++) begin
      rom[i] = `SOC_VECTOR(i);
    end
  end

  always_ff @(posedge clock) begin
    if (bus.cs[`SOC_REGION_ROM] && bus.read) begin
      readdata <= rom[bus.address[IDX_W+1:2]];
    end
  end

  // Masters must never target the ROM with a write
  a_no_rom_write: assert property (@(posedge clock)
    !(bus.write && bus.cs[`SOC_REGION_ROM]));

endmodule

// ==== include/soc_macros.svh ====
`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// Memory depths in 32-bit words
`define SOC_ROM_WORDS 32
`define SOC_RAM_WORDS 1024

// Region numbers sit in address bits 31:28
// Chipselect bit n belongs to region n
`define SOC_REGION_ROM 0
`define SOC_REGION_RAM 1
`define SOC_REGION_IO  2

// Each vector points at its own handler slot in RAM
`define SOC_VECTOR_STEP 16
`define SOC_VECTOR(i) ((32'(`SOC_REGION_RAM) << 28) + (32'(i) * `SOC_VECTOR_STEP))

`endif

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module soc_tb -o soc_sim

out=$(./obj_dir/soc_sim) || {
  echo "$out"
  exit 1
}
echo "$out"
echo "$out" | grep -q "^Everything OK$"

// ==== tb/soc_patterns.txt ====
# name master(c=cpu v=display) op(r w) address be data exp_read exp_leds exp_hex_digits
# all values in hex, leds and hex digits are the state expected after the operation
rom_cpu_0      c r 00000000 f 00000000 10000000 00000 00000000
rom_cpu_1      c r 00000004 f 00000000 10000010 00000 00000000
rom_cpu_31     c r 0000007c f 00000000 100001f0 00000 00000000
rom_vga_2      v r 00000008 f 00000000 10000020 00000 00000000
rom_vga_17     v r 00000044 f 00000000 10000110 00000 00000000
ram_full_wr    c w 10000100 f a1b2c3d4 00000000 00000 00000000
ram_full_rd    c r 10000100 f 00000000 a1b2c3d4 00000 00000000
ram_b0_wr      c w 10000100 1 000000ee 00000000 00000 00000000
ram_b2_wr      c w 10000100 4 00550000 00000000 00000 00000000
ram_merge_rd   c r 10000100 f 00000000 a155c3ee 00000 00000000
ram_b3_wr      c w 10000100 8 7f000000 00000000 00000 00000000
ram_merge2_rd  c r 10000100 f 00000000 7f55c3ee 00000 00000000
ram_zero_wr    c w 10000104 f 00000000 00000000 00000 00000000
ram_half_wr    c w 10000104 3 ffff1234 00000000 00000 00000000
ram_half_rd    c r 10000104 f 00000000 00001234 00000 00000000
ram_vga_rd     v r 10000100 f 00000000 7f55c3ee 00000 00000000
led_full_wr    c w 20000000 7 0003ffff 00000000 3ffff 00000000
led_full_rd    c r 20000000 f 00000000 0003ffff 3ffff 00000000
led_b1_wr      c w 20000000 2 0000a500 00000000 3a5ff 00000000
led_b3_wr      c w 20000000 8 ff000000 00000000 3a5ff 00000000
led_b2_wr      c w 20000000 4 00fe0000 00000000 2a5ff 00000000
led_ext_rd     c r 20000000 f 00000000 0002a5ff 2a5ff 00000000
hex_full_wr    c w 20000004 f 01234567 00000000 2a5ff 01234567
hex_b3_wr      c w 20000004 8 fe000000 00000000 2a5ff fe234567
hex_b3_rd      c r 20000004 f 00000000 fe234567 2a5ff fe234567
hex_full2_wr   c w 20000004 f 89abcdef 00000000 2a5ff 89abcdef
ram_pre_wr     c w 10000040 f 5a5a1234 00000000 2a5ff 89abcdef
unm3_wr        c w 30000040 f deadbeef 00000000 2a5ff 89abcdef
ram_keep_rd    c r 10000040 f 00000000 5a5a1234 2a5ff 89abcdef
unm3_rd        c r 30000040 f 00000000 00000000 2a5ff 89abcdef
unmf_vga_rd    v r f0000000 f 00000000 00000000 2a5ff 89abcdef
unmf_wr        c w f0000040 f 11111111 00000000 2a5ff 89abcdef
ram_keep2_rd   c r 10000040 f 00000000 5a5a1234 2a5ff 89abcdef

// ==== tb/soc_tb.sv ====
module soc_tb import bus_pkg::*, io_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int TIMEOUT = 50;
  localparam int RAM_WORDS = 1024;

  logic        clock;
  logic        rst_n;
  addr_t       cpu_address;
  logic        cpu_read;
  logic        cpu_write;
  data_t       cpu_writedata;
  be_t         cpu_be;
  data_t       cpu_readdata;
  logic        cpu_wait;
  addr_t       vga_address;
  logic        vga_read;
  data_t       vga_readdata;
  logic        vga_wait;
  led_t        leds;
  seg7_t [7:0] hex_segs;

  int          cycle_count = 0;
  int          pass_count = 0;
  int          fail_count = 0;
  logic [15:0] lfsr_q;
  data_t       ram_copy [RAM_WORDS];

  soc soc_inst (
    .clock(clock), .rst_n(rst_n),
    .cpu_address(cpu_address), .cpu_read(cpu_read), .cpu_write(cpu_write),
    .cpu_writedata(cpu_writedata), .cpu_be(cpu_be),
    .cpu_readdata(cpu_readdata), .cpu_wait(cpu_wait),
    .vga_address(vga_address), .vga_read(vga_read),
    .vga_readdata(vga_readdata), .vga_wait(vga_wait),
    .leds(leds), .hex_segs(hex_segs)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  always @(posedge clock) cycle_count <= cycle_count + 1;

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    if (s[0]) lfsr_next = (s >> 1) ^ 16'hb400;
    else lfsr_next = s >> 1;
  endfunction

  // One LFSR step per bit
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  // Standard active-low digit table, bit 0 is segment a
  function automatic seg7_t digit_segments(input nibble_t d);
    case (d)
      4'h0: digit_segments = 7'h40;
      4'h1: digit_segments = 7'h79;
      4'h2: digit_segments = 7'h24;
      4'h3: digit_segments = 7'h30;
      4'h4: digit_segments = 7'h19;
      4'h5: digit_segments = 7'h12;
      4'h6: digit_segments = 7'h02;
      4'h7: digit_segments = 7'h78;
      4'h8: digit_segments = 7'h00;
      4'h9: digit_segments = 7'h10;
      4'ha: digit_segments = 7'h08;
      4'hb: digit_segments = 7'h03;
      4'hc: digit_segments = 7'h46;
      4'hd: digit_segments = 7'h21;
      4'he: digit_segments = 7'h06;
      default: digit_segments = 7'h0e;
    endcase
  endfunction

  function automatic logic [55:0] expected_segs(input logic [31:0] h);
    for (int i = 0; i < 8; i++) begin
      expected_segs[7*i +: 7] = digit_segments(h[4*i +: 4]);
    end
  endfunction

  // Called at a falling edge, returns at the falling edge after completion
  task automatic cpu_access(input addr_t a, input logic wr, input data_t d, input be_t b,
                            output data_t rd, output int done_cycle);
    int n;
    cpu_address   = a;
    cpu_read      = !wr;
    cpu_write     = wr;
    cpu_writedata = d;
    cpu_be        = b;
    n = 0;
    #1;
    while (cpu_wait && n < TIMEOUT) begin
      @(negedge clock);
      #1;
      n++;
    end
    if (n >= TIMEOUT) begin
      $display("Timeout: CPU access to %h never completed in %0d cycles", a, TIMEOUT);
      $display("Something failed");
      $finish;
    end else begin
      rd = cpu_readdata;
      done_cycle = cycle_count;
      @(negedge clock);
      cpu_read  = 1'b0;
      cpu_write = 1'b0;
    end
  endtask

  task automatic vga_fetch(input addr_t a, output data_t rd, output int done_cycle);
    int n;
    vga_address = a;
    vga_read    = 1'b1;
    n = 0;
    #1;
    while (vga_wait && n < TIMEOUT) begin
      @(negedge clock);
      #1;
      n++;
    end
    if (n >= TIMEOUT) begin
      $display("Timeout: display fetch from %h never completed in %0d cycles", a, TIMEOUT);
      $display("Something failed");
      $finish;
    end else begin
      rd = vga_readdata;
      done_cycle = cycle_count;
      @(negedge clock);
      vga_read = 1'b0;
    end
  endtask

  task automatic replay_patterns(input int fd);
    string       name;
    string       master;
    string       op;
    string       line;
    logic [31:0] addr_v;
    logic [31:0] be_v;
    logic [31:0] data_v;
    logic [31:0] exp_rd;
    logic [31:0] exp_leds;
    logic [31:0] exp_hex;
    data_t       rd;
    int          done;
    int          code;
    bit          ok;
    forever begin
      code = $fscanf(fd, "%s", name);
      if (code != 1) break;
      if (name[0] == "#") begin
        void'($fgets(line, fd));
        continue;
      end
      code = $fscanf(fd, "%s %s %h %h %h %h %h %h", master, op, addr_v, be_v, data_v,
                     exp_rd, exp_leds, exp_hex);
      if (code != 8) begin
        $display("Pattern line for %s is incomplete", name);
        fail_count++;
        break;
      end
      if (master == "v") vga_fetch(addr_v, rd, done);
      else cpu_access(addr_v, op == "w", data_v, be_v[3:0], rd, done);
      ok = 1'b1;
      if (op == "r" && rd !== exp_rd) begin
        $display("Fail %s: expected read %h, actual %h", name, exp_rd, rd);
        ok = 1'b0;
      end
      if (leds !== exp_leds[17:0]) begin
        $display("Fail %s: expected leds %h, actual %h", name, exp_leds[17:0], leds);
        ok = 1'b0;
      end
      if (hex_segs !== expected_segs(exp_hex)) begin
        $display("Fail %s: expected hex_segs %h, actual %h", name, expected_segs(exp_hex),
                 hex_segs);
        ok = 1'b0;
      end
      if (ok) begin
        pass_count++;
        $display("ok %s", name);
      end else begin
        fail_count++;
      end
    end
  endtask

  // Same-cycle requests, the display master goes first
  task automatic check_arbitration();
    data_t cpu_rd;
    data_t vga_rd;
    int    cpu_done;
    int    vga_done;
    bit    ok;
    fork
      cpu_access(32'h0000_0024, 1'b0, '0, 4'hf, cpu_rd, cpu_done);
      vga_fetch(32'h0000_0014, vga_rd, vga_done);
    join
    ok = 1'b1;
    if (cpu_done - vga_done != 3) begin
      $display("Fail arbitration: expected gap 3, actual %0d", cpu_done - vga_done);
      ok = 1'b0;
    end
    if (cpu_rd !== 32'h1000_0090) begin
      $display("Fail arbitration: expected cpu read %h, actual %h", 32'h1000_0090, cpu_rd);
      ok = 1'b0;
    end
    if (vga_rd !== 32'h1000_0050) begin
      $display("Fail arbitration: expected vga read %h, actual %h", 32'h1000_0050, vga_rd);
      ok = 1'b0;
    end
    if (ok) begin
      pass_count++;
      $display("ok arbitration");
    end else begin
      fail_count++;
    end
  endtask

  task automatic random_ram_test();
    logic [31:0] idx_list [64];
    logic [31:0] idx;
    logic [31:0] data;
    data_t       rd;
    int          done;
    bit          ok;
    for (int i = 0; i < 64; i++) begin
      take_bits(10, idx);
      take_bits(32, data);
      idx_list[i] = idx;
      ram_copy[idx[9:0]] = data;
      cpu_access(32'h1000_0000 | (idx << 2), 1'b1, data, 4'hf, rd, done);
    end
    ok = 1'b1;
    for (int i = 0; i < 64; i++) begin
      idx = idx_list[i];
      cpu_access(32'h1000_0000 | (idx << 2), 1'b0, '0, 4'hf, rd, done);
      if (rd !== ram_copy[idx[9:0]]) begin
        $display("Fail random_ram word %0d: expected %h, actual %h", idx, ram_copy[idx[9:0]],
                 rd);
        ok = 1'b0;
      end
    end
    if (ok) begin
      pass_count++;
      $display("ok random_ram");
    end else begin
      fail_count++;
    end
  endtask

  initial begin
    int fd;
    rst_n         = 1'b0;
    cpu_address   = '0;
    cpu_read      = 1'b0;
    cpu_write     = 1'b0;
    cpu_writedata = '0;
    cpu_be        = '0;
    vga_address   = '0;
    vga_read      = 1'b0;
    lfsr_q        = 16'd59868;
    repeat (5) @(negedge clock);
    rst_n = 1'b1;
    @(negedge clock);
    if (cpu_wait !== 1'b0 || vga_wait !== 1'b0) begin
      $display("Fail reset_idle: expected waits 00, actual %b%b", cpu_wait, vga_wait);
      fail_count++;
    end else begin
      pass_count++;
      $display("ok reset_idle");
    end
    fd = $fopen("tb/soc_patterns.txt", "r");
    if (fd == 0) begin
      $display("Could not open the pattern file tb/soc_patterns.txt");
      $display("Something failed");
      $finish;
    end else begin
      replay_patterns(fd);
      $fclose(fd);
      check_arbitration();
      random_ram_test();
      $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
      if (fail_count == 0) begin
        $display("Everything OK");
      end else begin
        $display("Something failed");
      end
      $finish;
    end
  end

endmodule

// ==== vlog.f ====
+incdir+include
hw/bus_pkg.sv
hw/io_pkg.sv
hw/bus_if.sv
hw/bus_controller.sv
hw/scratch_ram.sv
hw/vector_rom.sv
hw/io_regs.sv
hw/soc.sv
tb/soc_tb.sv
